// File: bench/execRefModel.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

function automatic logic signedLess(input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    return (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b); // Unlike signs, the negative is less.
endfunction

// Expected bus word for one issued operation.
function automatic cdbT predictResult(input issueT w);
    cdbT             res;
    logic [xlen-1:0] b;
    logic [xlen-1:0] seqPc;
    logic [xlen-1:0] target;
    logic [xlen-1:0] sum;
    logic [4:0]      sh;
    res     = '0;
    res.tag = w.tag;
    seqPc   = w.pc + 32'd4;
    target  = w.pc + w.imm;
    b       = (w.op inside {opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli,
                            opSrai}) ? w.imm : w.rs2;
    sh      = b[4:0];
    case (w.op)
        opLui:           res.data = w.imm;
        opAuipc:         res.data = w.pc + w.imm;
        opAdd, opAddi:   res.data = w.rs1 + b;
        opSub:           res.data = w.rs1 - b;
        opAnd, opAndi:   res.data = w.rs1 & b;
        opOr, opOri:     res.data = w.rs1 | b;
        opXor, opXori:   res.data = w.rs1 ^ b;
        opSll, opSlli:   res.data = w.rs1 << sh;
        opSrl, opSrli:   res.data = w.rs1 >> sh;
        opSra, opSrai:   res.data = (w.rs1 >> sh) | (w.rs1[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
        opSltu, opSltiu: res.data = xlen'(w.rs1 < b);
        opSlt, opSlti:   res.data = xlen'(signedLess(w.rs1, b));
        opBeq:           res.jump = (w.rs1 == w.rs2);
        opBne:           res.jump = (w.rs1 != w.rs2);
        opBlt:           res.jump = signedLess(w.rs1, w.rs2);
        opBge:           res.jump = !signedLess(w.rs1, w.rs2);
        opBltu:          res.jump = (w.rs1 < w.rs2);
        opBgeu:          res.jump = !(w.rs1 < w.rs2);
        opJal:           res.jump = 1'b1;
        opJalr: begin
            res.jump = 1'b1;
            sum      = w.rs1 + w.imm;
            target   = {sum[xlen-1:1], 1'b0};
        end
        default:         res.data = '0;
    endcase
    if (res.jump) begin
        res.data = seqPc; // Every jump on the bus carries its link.
    end
    res.jumpPc = res.jump ? target : seqPc;
    return res;
endfunction

`endif

// File: bench/executeBench.sv
`timescale 1ns/1ns

module executeBench import execPkg::*;;

    localparam int waitLimit = 200;

    logic         clk = 1'b0;
    logic         rst;
    logic         issueValid;
    logic         issueReady;
    issueT        issue;
    logic         resultValid;
    logic         resultReady;
    cdbT          result;
    cdbT          expected [$];
    int           seed;
    int           errorCount = 0;
    int           checkCount = 0;
    int           edgeCount = 0;
    int           acceptEdge;
    int           firstResultEdge;
    int           stallCycles;
    bit           markFirst = 1'b0;
    bit           streaming;
    logic [3:0]   nextTag = '0;
    logic [199:0] readyPattern;
    logic [31:0]  pairA [4] = '{32'hffff_fffb, 32'hffff_fffb, 32'd3, 32'hffff_fff8};
    logic [31:0]  pairB [4] = '{32'hffff_fffb, 32'd3, 32'hffff_fffb, 32'hffff_fffe};

    `include "execRefModel.svh"

    executeUnit executeUnit_inst (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edgeCount++;
    end

    task automatic reportMismatch(input string name, input logic [31:0] want,
                                  input logic [31:0] got);
        $display("FAIL %s: expected %h, got %h", name, want, got);
        errorCount++;
    endtask

    task automatic abortRun(input string reason);
        $display("Timeout: %s", reason);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        $display("%s: %s", name, (errorCount == errorsBefore) ? "passed" : "failed");
    endtask

    function automatic logic [31:0] pickOperand();
        case ($unsigned($random(seed)) % 6)
            0: return 32'h7fff_ffff;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            3: return 32'h0000_0025; // Only the low five bits may shift.
            default: return $random(seed);
        endcase
    endfunction

    task automatic sendOp(input opT op, input logic [31:0] rs1, rs2, imm);
        issueT w;
        int    waited;
        w = '{op: op, pc: $random(seed) & 32'hffff_fffc, imm: imm, tag: nextTag, rs1: rs1,
              rs2: rs2};
        nextTag    = nextTag + 1'b1;
        issue      = w;
        issueValid = 1'b1;
        waited     = 0;
        while (!issueReady) begin
            @(posedge clk);
            #1;
            waited++;
            stallCycles++;
            if (waited > waitLimit) abortRun("issue handshake never completed");
        end
        @(posedge clk);
        #1;
        acceptEdge = edgeCount;
        expected.push_back(predictResult(w));
        issueValid = 1'b0;
    endtask

    task automatic waitDrain(input string what);
        int waited;
        waited = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > waitLimit) abortRun({what, ": result handshake never completed"});
        end
        @(posedge clk);
        #1;
    endtask

    // A transfer seen at the falling edge completes on the next rising edge.
    always @(negedge clk) begin
        cdbT want;
        if (!rst && resultValid && resultReady) begin
            if (markFirst) begin
                firstResultEdge = edgeCount + 1;
                markFirst       = 1'b0;
            end
            if (expected.size() == 0) begin
                $display("Result word with tag %h arrived with nothing expected", result.tag);
                errorCount++;
            end else begin
                want = expected.pop_front();
                checkCount++;
                assert (result.tag === want.tag)
                    else reportMismatch("result.tag", want.tag, result.tag);
                assert (result.data === want.data)
                    else reportMismatch("result.data", want.data, result.data);
                assert (result.jump === want.jump)
                    else reportMismatch("result.jump", want.jump, result.jump);
                assert (result.jumpPc === want.jumpPc)
                    else reportMismatch("result.jumpPc", want.jumpPc, result.jumpPc);
            end
        end
    end

    initial begin
        int errorsBefore;
        int idx;
        int firstAccept;
        seed        = 32'h52c5;
        rst         = 1'b1;
        issueValid  = 1'b0;
        issue       = '0;
        resultReady = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        errorsBefore = errorCount;
        assert (resultValid === 1'b0) else reportMismatch("resultValid", 0, resultValid);
        assert (issueReady === 1'b1) else reportMismatch("issueReady", 1, issueReady);
        endTest("reset", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 63; i++) begin
            idx = i % 21; // LUI, AUIPC and the 19 ALU operations.
            sendOp(idx < 2 ? opT'(idx + 1) : opT'(idx + 9), pickOperand(), pickOperand(),
                   pickOperand());
        end
        waitDrain("arithmetic");
        endTest("arithmetic", errorsBefore);

        errorsBefore = errorCount;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 4; p++) begin
                sendOp(opT'(opBeq + k), pairA[p], pairB[p], $random(seed) & 32'hffff_fffe);
            end
        end
        waitDrain("branches");
        endTest("branches", errorsBefore);

        errorsBefore = errorCount;
        for (int j = 0; j < 8; j++) begin
            sendOp((j % 2 == 1) ? opJalr : opJal, $random(seed) & 32'hffff_fffe, pickOperand(),
                   $random(seed) | 32'h1); // Odd sum, so JALR must clear bit 0.
        end
        waitDrain("jumps");
        endTest("jumps", errorsBefore);

        errorsBefore = errorCount;
        for (int r = 0; r < 200; r++) begin
            readyPattern[r] = $random(seed);
        end
        streaming = 1'b1;
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    sendOp(opT'($unsigned($random(seed)) % 30), pickOperand(), pickOperand(),
                           pickOperand());
                end
                streaming = 1'b0;
            end
            for (int c = 0; c < 200 && streaming; c++) begin
                resultReady = readyPattern[c];
                @(posedge clk);
                #1;
            end
        join
        resultReady = 1'b1;
        waitDrain("back-pressure");
        endTest("back-pressure", errorsBefore);

        errorsBefore = errorCount;
        stallCycles  = 0;
        markFirst    = 1'b1;
        for (int i = 0; i < 20; i++) begin
            sendOp(opT'(opAddi + $unsigned($random(seed)) % 19), pickOperand(), pickOperand(),
                   pickOperand());
            if (i == 0) firstAccept = acceptEdge;
        end
        waitDrain("throughput");
        assert (stallCycles == 0) else reportMismatch("stallCycles", 0, stallCycles);
        assert (firstResultEdge - firstAccept == 3)
            else reportMismatch("firstResultLatency", 3, firstResultEdge - firstAccept);
        endTest("throughput", errorsBefore);

        $display("Summary: %0d words checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+bench
source/execPkg.sv
source/skidBuffer.sv
source/aluPath.sv
source/branchPath.sv
source/resultMerge.sv
source/executeUnit.sv
bench/executeBench.sv

// File: source/aluPath.sv
`timescale 1ns/1ns

module aluPath import execPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   inValid,
    input  logic   advance,
    input  issueT  inIssue,
    output logic   outValid,
    output aluOutT out
);

    logic [xlen-1:0] operandB;
    logic [4:0]      shamt;
    logic [xlen-1:0] result;

    // Immediate forms take imm as the second operand.
    always_comb begin
        case (inIssue.op)
            opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai: begin
                operandB = inIssue.imm;
            end
            default: begin
                operandB = inIssue.rs2;
            end
        endcase
    end

    assign shamt = operandB[4:0];

    always_comb begin
        case (inIssue.op)
            opLui:          result = inIssue.imm;
            opAuipc:        result = inIssue.pc + inIssue.imm;
            opAddi, opAdd:  result = inIssue.rs1 + operandB;
            opSub:          result = inIssue.rs1 - operandB;
            opSlti, opSlt: begin
                result = {{(xlen-1){1'b0}}, $signed(inIssue.rs1) < $signed(operandB)};
            end
            opSltiu, opSltu: begin
                result = {{(xlen-1){1'b0}}, inIssue.rs1 < operandB};
            end
            opXori, opXor:  result = inIssue.rs1 ^ operandB;
            opOri, opOr:    result = inIssue.rs1 | operandB;
            opAndi, opAnd:  result = inIssue.rs1 & operandB;
            opSlli, opSll:  result = inIssue.rs1 << shamt;
            opSrli, opSrl:  result = inIssue.rs1 >> shamt;
            opSrai, opSra:  result = $signed(inIssue.rs1) >>> shamt;
            default:        result = '0; // Branches and jumps carry their link elsewhere.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (advance) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out.tag  <= inIssue.tag;
            out.data <= result;
        end
    end

endmodule

// File: source/branchPath.sv
`timescale 1ns/1ns

module branchPath import execPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      advance,
    input  issueT     inIssue,
    output branchOutT out
);

    logic            isControl;
    logic            taken;
    logic [xlen-1:0] seqPc;
    logic [xlen-1:0] jumpTarget;
    logic            controlReg;
    logic            jumpReg;
    logic [xlen-1:0] targetReg;
    logic [xlen-1:0] linkReg;

    assign seqPc = inIssue.pc + xlen'(4);

    always_comb begin
        isControl = 1'b1;
        case (inIssue.op)
            opBeq:         taken = inIssue.rs1 == inIssue.rs2;
            opBne:         taken = inIssue.rs1 != inIssue.rs2;
            opBlt:         taken = $signed(inIssue.rs1) < $signed(inIssue.rs2);
            opBge:         taken = $signed(inIssue.rs1) >= $signed(inIssue.rs2);
            opBltu:        taken = inIssue.rs1 < inIssue.rs2;
            opBgeu:        taken = inIssue.rs1 >= inIssue.rs2;
            opJal, opJalr: taken = 1'b1;
            default: begin
                isControl = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    // JALR clears bit 0 of the computed address.
    assign jumpTarget = (inIssue.op == opJalr) ?
        ((inIssue.rs1 + inIssue.imm) & ~xlen'(1)) : (inIssue.pc + inIssue.imm);

    always_ff @(posedge clk) begin
        if (rst) begin
            controlReg <= 1'b0;
            jumpReg    <= 1'b0;
        end else if (advance) begin
            controlReg <= isControl;
            jumpReg    <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            targetReg <= taken ? jumpTarget : seqPc;
            linkReg   <= seqPc;
        end
    end

    assign out = '{isControl: controlReg, jump: jumpReg, target: targetReg, link: linkReg};

endmodule

// File: source/execPkg.sv
package execPkg;

    localparam int xlen = 32;
    localparam int tagWidth = 4; // Reorder-buffer tag, the "nick".

    typedef enum logic [5:0] {
        opNone,
        opLui,
        opAuipc,
        opJal,
        opJalr,
        opBeq,
        opBne,
        opBlt,
        opBge,
        opBltu,
        opBgeu,
        opAddi,
        opSlti,
        opSltiu,
        opXori,
        opOri,
        opAndi,
        opSlli,
        opSrli,
        opSrai,
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd
    } opT;

    typedef struct packed {
        opT                  op;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     imm; // Sign-extended by the decoder.
        logic [tagWidth-1:0] tag;
        logic [xlen-1:0]     rs1;
        logic [xlen-1:0]     rs2;
    } issueT;

    typedef struct packed {
        logic [tagWidth-1:0] tag;
        logic [xlen-1:0]     data;
    } aluOutT;

    typedef struct packed {
        logic            isControl;
        logic            jump;
        logic [xlen-1:0] target; // Falls back to pc + 4 when not jumping.
        logic [xlen-1:0] link;
    } branchOutT;

    typedef struct packed {
        logic [tagWidth-1:0] tag;
        logic [xlen-1:0]     data;
        logic                jump;
        logic [xlen-1:0]     jumpPc;
    } cdbT;

endpackage

// File: source/executeUnit.sv
`timescale 1ns/1ns

module executeUnit import execPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  issueValid,
    output logic  issueReady,
    input  issueT issue,
    output logic  resultValid,
    input  logic  resultReady,
    output cdbT   result
);

    logic      stageValid;
    issueT     stageIssue;
    logic      advance;
    logic      pathValid;
    aluOutT    aluOut;
    branchOutT branchOut;

    skidBuffer #(
        .payloadT(issueT)
    ) issueSkid (
        .clk     (clk),
        .rst     (rst),
        .inValid (issueValid),
        .inReady (issueReady),
        .inData  (issue),
        .outValid(stageValid),
        .outReady(advance),
        .outData (stageIssue)
    );

    aluPath aluStage (
        .clk     (clk),
        .rst     (rst),
        .inValid (stageValid),
        .advance (advance),
        .inIssue (stageIssue),
        .outValid(pathValid),
        .out     (aluOut)
    );

    branchPath branchStage (
        .clk    (clk),
        .rst    (rst),
        .advance(advance),
        .inIssue(stageIssue),
        .out    (branchOut)
    );

    resultMerge merge (
        .clk      (clk),
        .rst      (rst),
        .inValid  (pathValid), // One valid covers both paths.
        .advance  (advance),
        .aluOut   (aluOut),
        .branchOut(branchOut),
        .outValid (resultValid),
        .outReady (resultReady),
        .out      (result)
    );

endmodule

// File: source/resultMerge.sv
`timescale 1ns/1ns

module resultMerge import execPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      inValid,
    output logic      advance,
    input  aluOutT    aluOut,
    input  branchOutT branchOut,
    output logic      outValid,
    input  logic      outReady,
    output cdbT       out
);

    cdbT mergedWord;

    always_comb begin
        mergedWord.tag = aluOut.tag;
        if (branchOut.isControl && branchOut.jump) begin
            mergedWord.data = branchOut.link; // Jumps write pc + 4 to rd.
        end else begin
            mergedWord.data = aluOut.data;
        end
        mergedWord.jump   = branchOut.jump;
        mergedWord.jumpPc = branchOut.target;
    end

    // Its input ready paces both path registers.
    skidBuffer #(
        .payloadT(cdbT)
    ) outSkid (
        .clk     (clk),
        .rst     (rst),
        .inValid (inValid),
        .inReady (advance),
        .inData  (mergedWord),
        .outValid(outValid),
        .outReady(outReady),
        .outData (out)
    );

endmodule

// File: source/skidBuffer.sv
`timescale 1ns/1ns

module skidBuffer #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    mainValid;
    logic    spareValid;
    payloadT mainData;
    payloadT spareData;
    logic    inFire;
    logic    mainFree;

    assign inReady  = !spareValid; // Registered, so a stall shows upstream a cycle late.
    assign inFire   = inValid && inReady;
    assign mainFree = !mainValid || outReady;
    assign outValid = mainValid;
    assign outData  = mainData;

    always_ff @(posedge clk) begin
        if (rst) begin
            mainValid  <= 1'b0;
            spareValid <= 1'b0;
        end else if (mainFree) begin
            if (spareValid) begin
                mainValid  <= 1'b1; // The spare drains first to keep order.
                spareValid <= 1'b0;
            end else begin
                mainValid <= inFire;
            end
        end else if (inFire) begin
            spareValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mainFree) begin
            if (spareValid) begin
                mainData <= spareData;
            end else if (inFire) begin
                mainData <= inData;
            end
        end else if (inFire) begin
            spareData <= inData;
        end
    end

endmodule
